// File: common/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// ##############################
// Frame and buffer sizes
// ##############################

// Width of one data byte on the serial line.
`define UART_DATA_WIDTH 8

// Log2 of the entries in each FIFO.
`define UART_FIFO_LOGDEPTH 3

// ##############################
// Bit timing
// ##############################

// Clock cycles in one serial bit time.
`define UART_CLKS_PER_BIT 8

// Must hold UART_CLKS_PER_BIT - 1.
`define UART_CYCLE_W 4

`endif

// File: common/uart_pkg.sv
`include "uart_config.svh"

package uart_pkg;

  // ##############################
  // Payload and counters
  // ##############################

  typedef logic [`UART_DATA_WIDTH-1:0] byte_t;

  // Data bit position within a frame.
  typedef logic [2:0] bit_index_t;

  // Cycles elapsed within one bit time.
  typedef logic [`UART_CYCLE_W-1:0] cycle_count_t;

  // ##############################
  // State machines
  // ##############################

  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_stop
  } tx_state_t;

  // Receiver follows the same frame phases.
  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

endpackage

// File: fifo/async_ram_dp.sv
module async_ram_dp #(
  parameter int awidth = 3,
  parameter int dwidth = 8
) (
  input  logic              clk,

  input  logic [dwidth-1:0] d0,
  input  logic [awidth-1:0] addr0,
  input  logic              we0,
  output logic [dwidth-1:0] q0,

  input  logic [dwidth-1:0] d1,
  input  logic [awidth-1:0] addr1,
  input  logic              we1,
  output logic [dwidth-1:0] q1
);

  logic [dwidth-1:0] mem [2**awidth];

  // Both ports may write; port 1 wins on a shared address.
  always_ff @(posedge clk) begin
    if (we0) begin
      mem[addr0] <= d0;
    end
    if (we1) begin
      mem[addr1] <= d1;
    end
  end

  // Reads are combinational.
  assign q0 = mem[addr0];
  assign q1 = mem[addr1];

endmodule

// File: fifo/fifo.sv
module fifo #(
  parameter int width    = 8,
  parameter int logdepth = 3
) (
  input  logic             clk,
  input  logic             rst,

  input  logic             enq_valid,
  input  logic [width-1:0] enq_data,
  output logic             enq_ready,

  output logic             deq_valid,
  output logic [width-1:0] deq_data,
  input  logic             deq_ready
);

  logic [logdepth-1:0] write_ptr;
  logic [logdepth-1:0] read_ptr;
  logic [logdepth-1:0] write_ptr_next;
  logic [logdepth-1:0] read_ptr_next;
  logic                write_wrap;
  logic                read_wrap;
  logic                do_enq;
  logic                do_deq;

  // ##############################
  // Storage
  // ##############################

  // Port 0 writes at the tail, port 1 reads at the head.
  async_ram_dp #(
    .awidth(logdepth),
    .dwidth(width)
  ) buffer (
    .clk  (clk),
    .d0   (enq_data),
    .addr0(write_ptr),
    .we0  (do_enq),
    .q0   (),
    .d1   ({width{1'b0}}),
    .addr1(read_ptr),
    .we1  (1'b0),
    .q1   (deq_data)
  );

  // ##############################
  // Pointers
  // ##############################

  assign do_enq = enq_valid && enq_ready;
  assign do_deq = deq_valid && deq_ready;

  assign write_ptr_next = write_ptr + 1'b1;
  assign read_ptr_next  = read_ptr + 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      write_ptr  <= '0;
      write_wrap <= 1'b0;
    end else if (do_enq) begin
      write_ptr <= write_ptr_next;
      // Lap marker flips on rollover.
      if (write_ptr_next == '0) begin
        write_wrap <= ~write_wrap;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_ptr  <= '0;
      read_wrap <= 1'b0;
    end else if (do_deq) begin
      read_ptr <= read_ptr_next;
      if (read_ptr_next == '0) begin
        read_wrap <= ~read_wrap;
      end
    end
  end

  // Equal pointers mean full on different laps, empty on the same lap.
  assign enq_ready = !((write_ptr == read_ptr) && (write_wrap != read_wrap));
  assign deq_valid = !((write_ptr == read_ptr) && (write_wrap == read_wrap));

endmodule

// File: logic/uart_tx.sv
`include "uart_config.svh"

module uart_tx (
  input  logic            clk,
  input  logic            rst,
  input  logic            data_valid,
  input  uart_pkg::byte_t data_in,
  output logic            data_ready,
  output logic            serial_out
);

  import uart_pkg::*;

  localparam cycle_count_t bit_last   = cycle_count_t'(`UART_CLKS_PER_BIT - 1);
  localparam bit_index_t   last_index = bit_index_t'(`UART_DATA_WIDTH - 1);

  tx_state_t    state;
  cycle_count_t timer;
  bit_index_t   bit_idx;
  byte_t        shift_q;
  logic         accept;
  logic         bit_done;

  assign data_ready = (state == tx_idle);
  assign accept     = data_valid && data_ready;
  assign bit_done   = (timer == bit_last);

  // ##############################
  // Frame sequencing
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= tx_idle;
      timer      <= '0;
      bit_idx    <= '0;
      serial_out <= 1'b1;
    end else begin
      timer <= bit_done ? '0 : timer + 1'b1;
      case (state)
        tx_idle: begin
          timer <= '0;
          if (accept) begin
            state      <= tx_start;
            serial_out <= 1'b0;
          end
        end
        tx_start: begin
          if (bit_done) begin
            state      <= tx_data;
            bit_idx    <= '0;
            serial_out <= shift_q[0];
          end
        end
        tx_data: begin
          if (bit_done) begin
            if (bit_idx == last_index) begin
              state      <= tx_stop;
              serial_out <= 1'b1;
            end else begin
              bit_idx    <= bit_idx + 1'b1;
              serial_out <= shift_q[0];
            end
          end
        end
        tx_stop: begin
          if (bit_done) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // Bit 0 always holds the next bit to send.
  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= data_in;
    end else if (bit_done && (state == tx_start || state == tx_data)) begin
      shift_q <= {1'b1, shift_q[`UART_DATA_WIDTH-1:1]};
    end
  end

endmodule

// File: logic/uart_rx.sv
`include "uart_config.svh"

module uart_rx (
  input  logic            clk,
  input  logic            rst,
  input  logic            serial_in,
  output logic            byte_valid,
  output uart_pkg::byte_t byte_out
);

  import uart_pkg::*;

  localparam cycle_count_t bit_last   = cycle_count_t'(`UART_CLKS_PER_BIT - 1);
  localparam cycle_count_t half_last  = cycle_count_t'(`UART_CLKS_PER_BIT / 2 - 1);
  localparam bit_index_t   last_index = bit_index_t'(`UART_DATA_WIDTH - 1);

  rx_state_t    state;
  cycle_count_t timer;
  bit_index_t   bit_idx;
  byte_t        shift_q;
  logic         line_q;
  logic         fall;
  logic         sample;

  // Previous line level, for start edge detection.
  always_ff @(posedge clk) begin
    if (rst) begin
      line_q <= 1'b1;
    end else begin
      line_q <= serial_in;
    end
  end

  assign fall = line_q && !serial_in;

  // Data bits are sampled a full bit time after the mid-start point.
  assign sample = (state == rx_data) && (timer == bit_last);

  // ##############################
  // Frame detection
  // ##############################

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= rx_idle;
      timer      <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      timer      <= timer + 1'b1;
      case (state)
        rx_idle: begin
          timer <= '0;
          if (fall) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          // Mid-start check rejects short glitches.
          if (timer == half_last) begin
            timer   <= '0;
            bit_idx <= '0;
            state   <= serial_in ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (timer == bit_last) begin
            timer <= '0;
            if (bit_idx == last_index) begin
              state <= rx_stop;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        rx_stop: begin
          if (timer == bit_last) begin
            // A low stop bit drops the frame.
            byte_valid <= serial_in;
            state      <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // LSB arrives first, so bits enter at the top.
  always_ff @(posedge clk) begin
    if (sample) begin
      shift_q <= {serial_in, shift_q[`UART_DATA_WIDTH-1:1]};
    end
  end

  assign byte_out = shift_q;

endmodule

// File: logic/uart_fifo_top.sv
`include "uart_config.svh"

module uart_fifo_top (
  input  logic            clk,
  input  logic            rst,

  input  logic            enq_valid,
  input  uart_pkg::byte_t enq_data,
  output logic            enq_ready,

  output logic            deq_valid,
  output uart_pkg::byte_t deq_data,
  input  logic            deq_ready,

  output logic            serial_out,
  input  logic            serial_in,
  output logic            rx_overflow
);

  import uart_pkg::*;

  logic  tx_pending;
  byte_t tx_byte;
  logic  tx_take;
  logic  rx_strobe;
  byte_t rx_byte;
  logic  rx_space;

  // ##############################
  // Transmit path
  // ##############################

  fifo #(
    .width   (`UART_DATA_WIDTH),
    .logdepth(`UART_FIFO_LOGDEPTH)
  ) tx_fifo (
    .clk      (clk),
    .rst      (rst),
    .enq_valid(enq_valid),
    .enq_data (enq_data),
    .enq_ready(enq_ready),
    .deq_valid(tx_pending),
    .deq_data (tx_byte),
    .deq_ready(tx_take)
  );

  uart_tx tx0 (
    .clk       (clk),
    .rst       (rst),
    .data_valid(tx_pending),
    .data_in   (tx_byte),
    .data_ready(tx_take),
    .serial_out(serial_out)
  );

  // ##############################
  // Receive path
  // ##############################

  uart_rx rx0 (
    .clk       (clk),
    .rst       (rst),
    .serial_in (serial_in),
    .byte_valid(rx_strobe),
    .byte_out  (rx_byte)
  );

  fifo #(
    .width   (`UART_DATA_WIDTH),
    .logdepth(`UART_FIFO_LOGDEPTH)
  ) rx_fifo (
    .clk      (clk),
    .rst      (rst),
    .enq_valid(rx_strobe),
    .enq_data (rx_byte),
    .enq_ready(rx_space),
    .deq_valid(deq_valid),
    .deq_data (deq_data),
    .deq_ready(deq_ready)
  );

  // Sticky until reset; the dropped byte is lost.
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_overflow <= 1'b0;
    end else if (rx_strobe && !rx_space) begin
      rx_overflow <= 1'b1;
    end
  end

endmodule

// File: test/tb_uart_fifo.sv
`include "uart_config.svh"

module tb_uart_fifo;

  import uart_pkg::*;

  localparam int num_tests    = 3;
  localparam int frame_cycles = 10 * `UART_CLKS_PER_BIT;
  localparam int fifo_depth   = 1 << `UART_FIFO_LOGDEPTH;

  logic  clk;
  logic  rst;
  logic  enq_valid;
  byte_t enq_data;
  logic  enq_ready;
  logic  deq_valid;
  byte_t deq_data;
  logic  deq_ready;
  logic  serial_line;
  logic  rx_overflow;

  logic [31:0] lcg_state;
  byte_t       ref_q[$];
  bit          table_loaded;

  string test_name     [num_tests];
  int    test_count    [num_tests];
  bit    test_read     [num_tests];
  bit    test_overflow [num_tests];

  // Serial output is looped straight back into the receiver.
  uart_fifo_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .enq_valid  (enq_valid),
    .enq_data   (enq_data),
    .enq_ready  (enq_ready),
    .deq_valid  (deq_valid),
    .deq_data   (deq_data),
    .deq_ready  (deq_ready),
    .serial_out (serial_line),
    .serial_in  (serial_line),
    .rx_overflow(rx_overflow)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ##############################
  // Failure reporting and checks
  // ##############################

  task automatic stop_with_failure();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic abort_run(input string why);
    $display("error: %s", why);
    stop_with_failure();
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      $display("mismatch %s: expected %02h, actual %02h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch %s: expected %0b, actual %0b", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("mismatch %s: expected %0d bytes, actual %0d bytes", name, exp, act);
      stop_with_failure();
    end
  endtask

  // Numerical Recipes constants.
  function automatic byte_t next_random_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:24];
  endfunction

  task automatic pop_and_check(input string name);
    byte_t exp;
    if (ref_q.size() == 0) begin
      abort_run($sformatf("%s: a byte came out that was never sent", name));
    end else begin
      exp = ref_q.pop_front();
      check_byte(name, exp, deq_data);
    end
  endtask

  // ##############################
  // Sequences
  // ##############################

  task automatic load_table();
    test_name[0]     = "single";
    test_count[0]    = 1;
    test_read[0]     = 1'b1;
    test_overflow[0] = 1'b0;
    test_name[1]     = "burst";
    test_count[1]    = 20;
    test_read[1]     = 1'b1;
    test_overflow[1] = 1'b0;
    test_name[2]     = "overflow";
    test_count[2]    = 12;
    test_read[2]     = 1'b0;
    test_overflow[2] = 1'b1;
  endtask

  task automatic apply_reset();
    rst       = 1'b1;
    enq_valid = 1'b0;
    deq_ready = 1'b0;
    ref_q.delete();
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    check_bit("reset serial_out", 1'b1, serial_line);
    check_bit("reset deq_valid", 1'b0, deq_valid);
    check_bit("reset rx_overflow", 1'b0, rx_overflow);
    check_bit("reset enq_ready", 1'b1, enq_ready);
  endtask

  // Bit k of the frame is centered 4 cycles into its bit time.
  task automatic check_frame_format();
    byte_t b;
    logic  exp_bit;
    int    waited;
    b = next_random_byte();
    ref_q.push_back(b);
    enq_valid = 1'b1;
    enq_data  = b;
    while (!enq_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1 enq_valid = 1'b0;
    repeat (`UART_CLKS_PER_BIT / 2) @(posedge clk);
    for (int k = 0; k < 10; k++) begin
      if (k > 0) begin
        repeat (`UART_CLKS_PER_BIT) @(posedge clk);
      end
      #1;
      if (k == 0) begin
        exp_bit = 1'b0;
      end else if (k == 9) begin
        exp_bit = 1'b1;
      end else begin
        exp_bit = b[k-1];
      end
      check_bit($sformatf("frame bit %0d", k), exp_bit, serial_line);
    end
    waited = 0;
    while (!deq_valid) begin
      if (waited > frame_cycles) begin
        abort_run("frame: the looped-back byte never reached deq_valid");
      end
      @(posedge clk);
      #1;
      waited++;
    end
    deq_ready = 1'b1;
    pop_and_check("frame");
    @(posedge clk);
    #1 deq_ready = 1'b0;
    check_bit("frame empty", 1'b0, deq_valid);
  endtask

  task automatic run_test(input int idx);
    string name;
    int    count;
    int    sent;
    int    received;
    int    exp_count;
    bit    saw_stall;
    byte_t payload[$];
    name      = test_name[idx];
    count     = test_count[idx];
    exp_count = test_overflow[idx] ? fifo_depth : count;
    sent      = 0;
    received  = 0;
    saw_stall = 1'b0;
    for (int i = 0; i < count; i++) begin
      payload.push_back(next_random_byte());
      ref_q.push_back(payload[i]);
    end
    // Valid holds its byte until a cycle where enq_ready is high.
    while (sent < count || (test_read[idx] && received < exp_count)) begin
      if (test_read[idx]) begin
        deq_ready = 1'b1;
        if (deq_valid) begin
          pop_and_check(name);
          received++;
        end
      end
      if (sent < count) begin
        enq_valid = 1'b1;
        enq_data  = payload[sent];
        if (enq_ready) begin
          sent++;
        end else begin
          saw_stall = 1'b1;
        end
      end else begin
        enq_valid = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    enq_valid = 1'b0;
    if (!test_read[idx]) begin
      repeat (count * frame_cycles) @(posedge clk);
      #1 deq_ready = 1'b1;
      while (deq_valid) begin
        pop_and_check(name);
        received++;
        @(posedge clk);
        #1;
      end
    end
    check_count(name, exp_count, received);
    repeat (frame_cycles) begin
      check_bit($sformatf("%s deq_valid idle", name), 1'b0, deq_valid);
      @(posedge clk);
      #1;
    end
    deq_ready = 1'b0;
    check_bit($sformatf("%s rx_overflow", name), test_overflow[idx], rx_overflow);
    if (count > fifo_depth + 1) begin
      check_bit($sformatf("%s enq_ready stall", name), 1'b1, saw_stall);
    end
  endtask

  // ##############################
  // Main flow and watchdog
  // ##############################

  initial begin
    rst          = 1'b1;
    enq_valid    = 1'b0;
    enq_data     = '0;
    deq_ready    = 1'b0;
    lcg_state    = 32'h6c002973;
    table_loaded = 1'b0;
    load_table();
    table_loaded = 1'b1;
    apply_reset();
    check_frame_format();
    for (int i = 0; i < num_tests; i++) begin
      apply_reset();
      run_test(i);
    end
    $display("*** PASSED ***");
    $finish;
  end

  // Twice the serial time of every byte, plus room for resets and idle checks.
  initial begin
    int total;
    int limit;
    wait (table_loaded);
    total = 1;
    for (int i = 0; i < num_tests; i++) begin
      total += test_count[i];
    end
    limit = total * frame_cycles * 4 * 2 + 4000;
    #(limit);
    abort_run($sformatf("timeout, the tests did not finish within %0d time units", limit));
  end

endmodule

// File: all.f
+incdir+common
common/uart_pkg.sv
fifo/async_ram_dp.sv
fifo/fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_fifo_top.sv
test/tb_uart_fifo.sv
